/* Bender.yml */
package:
  name: ara_cluster

sources:
  - files:
      - verilog/cluster_pkg.sv
      - verilog/op_pkg.sv
      - verilog/req_stream_if.sv
      - verilog/req_fork_node.sv
      - verilog/req_fork_tree.sv
      - verilog/vector_cluster.sv
      - verilog/ring_spill.sv
      - verilog/resp_join_tree.sv
      - verilog/ara_cluster_top.sv
  - target: test
    files:
      - verif/ara_cluster_props.sv
      - verif/tb_ara_cluster.sv

/* verif/ara_cluster_props.sv */
////////////////////////////////////////////////////////////////////////////
// Handshake properties of the cluster system ports
////////////////////////////////////////////////////////////////////////////

module ara_cluster_props import cluster_pkg::*; (
  input logic clk_i,
  input logic reset_i,
  input logic req_ready_o,
  input logic resp_valid_o,
  input logic resp_ready_i,
  input vec_t resp_data_o
);

  int assert_fails = 0;

  // Response held until taken
  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
    else begin
      $error("Response dropped or changed before it was accepted");
      assert_fails++;
    end

  a_resp_reset: assert property (@(posedge clk_i) reset_i |=> !resp_valid_o)
    else begin
      $error("Response valid right after reset");
      assert_fails++;
    end

  a_ready_known: assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown(req_ready_o))
    else begin
      $error("Request ready is unknown");
      assert_fails++;
    end

endmodule : ara_cluster_props

bind ara_cluster_top ara_cluster_props i_props (
  .clk_i       (clk_i       ),
  .reset_i     (reset_i     ),
  .req_ready_o (req_ready_o ),
  .resp_valid_o(resp_valid_o),
  .resp_ready_i(resp_ready_i),
  .resp_data_o (resp_data_o )
);

/* verif/tb_ara_cluster.sv */
////////////////////////////////////////////////////////////////////////////
// Vector cluster system testbench
// Directed and random requests, checked in order against a vector model
////////////////////////////////////////////////////////////////////////////

module tb_ara_cluster import cluster_pkg::*; import op_pkg::*; ();

  localparam int NrDirected = 8;
  localparam int NrRandom   = 200;
  localparam int CycleLimit = 40 * (NrDirected + NrRandom) + 100;

  logic     clk_i;
  logic     reset_i;
  logic     req_valid_i;
  logic     req_ready_o;
  op_t      req_op_i;
  operand_t req_operand_i;
  logic     resp_valid_o;
  logic     resp_ready_i;
  vec_t     resp_data_o;

  vec_t     model_vec;
  vec_t     exp_q [$];
  int       n_req;
  int       n_resp;
  int       cycle_cnt;
  logic     random_ready;
  int unsigned seed_val;
  op_t      rnd_op [NrRandom];
  operand_t rnd_operand [NrRandom];

  ara_cluster_top dut (.*);

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_vec(input vec_t got, input vec_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                          $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                          $time, what, got, exp));
  endtask

  // Expected vector after one operation
  function automatic vec_t next_vec(input vec_t cur, input op_t op, input operand_t operand);
    vec_t  res;
    elem_t e;
    int    left;
    for (int i = 0; i < NrClusters; i++) begin
      left = (i + NrClusters - 1) % NrClusters;
      if (op == OpSet)
        e = operand + elem_t'(i);
      else if (op == OpSlide)
        e = cur[left*ElemWidth +: ElemWidth];
      else
        e = cur[i*ElemWidth +: ElemWidth] + operand;
      res[i*ElemWidth +: ElemWidth] = e;
    end
    return res;
  endfunction

  // Called one unit after a rising edge, returns at the same point
  task automatic send_req(input op_t op, input operand_t operand);
    req_valid_i   = 1'b1;
    req_op_i      = op;
    req_operand_i = operand;
    do @(negedge clk_i); while (!req_ready_o);
    model_vec = next_vec(model_vec, op, operand);
    exp_q.push_back(model_vec);
    n_req++;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (n_resp < n_req) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response compare and back-pressure
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (dut.i_props.assert_fails != 0)
      abort_run("A handshake assertion on the DUT ports has failed");
    if (!reset_i && resp_valid_o && resp_ready_i) begin
      if (exp_q.size() == 0)
        abort_run("A response arrived while no request was outstanding");
      check_vec(resp_data_o, exp_q.pop_front(), "response vector");
      n_resp++;
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (random_ready) resp_ready_i = ($urandom_range(0, 3) != 0);
    else              resp_ready_i = 1'b1;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > CycleLimit)
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d responses received",
                          cycle_cnt, n_resp, n_req));
  end

  initial begin
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    req_valid_i   = 1'b0;
    req_op_i      = OpSet;
    req_operand_i = '0;
    resp_ready_i  = 1'b1;
    random_ready  = 1'b0;
    model_vec     = '0;
    n_req         = 0;
    n_resp        = 0;
    cycle_cnt     = 0;
    seed_val      = $urandom(32'ha18c_fcf2);
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    check_bit(resp_valid_o, 1'b0, "resp_valid_o after reset");
    check_bit(req_ready_o, 1'b1, "req_ready_o after reset");
    @(posedge clk_i);
    #1;

    // Zero vector, then SET and ADD with wraparound
    send_req(OpAdd, 16'h0000);
    send_req(OpSet, 16'h1234);
    send_req(OpSet, 16'hfffe);
    send_req(OpAdd, 16'h0003);
    send_req(OpAdd, 16'hffff);
    wait_drained();

    // One rotation, then two in a row
    send_req(OpSlide, 16'h0000);
    wait_drained();
    send_req(OpSlide, 16'h0000);
    send_req(OpSlide, 16'h0000);
    wait_drained();

    // Random ops, a quarter of the operands close to the wrap point
    for (int i = 0; i < NrRandom; i++) begin
      rnd_op[i]      = op_t'($urandom_range(0, 3));
      rnd_operand[i] = ($urandom_range(0, 3) == 0) ? operand_t'(16'hfff0 + $urandom_range(0, 15))
                                                   : operand_t'($urandom);
    end
    random_ready = 1'b1;
    for (int i = 0; i < NrRandom; i++) send_req(rnd_op[i], rnd_operand[i]);
    wait_drained();
    random_ready = 1'b0;

    // A duplicated response would find an empty queue here
    repeat (20) @(negedge clk_i);
    $display("TEST OK");
    $finish;
  end

endmodule : tb_ara_cluster

/* verilog.f */
verilog/cluster_pkg.sv
verilog/op_pkg.sv
verilog/req_stream_if.sv
verilog/req_fork_node.sv
verilog/req_fork_tree.sv
verilog/vector_cluster.sv
verilog/ring_spill.sv
verilog/resp_join_tree.sv
verilog/ara_cluster_top.sv
verif/ara_cluster_props.sv
verif/tb_ara_cluster.sv

/* verilog/ara_cluster_top.sv */
////////////////////////////////////////////////////////////////////////////
// Vector cluster system
// Fork tree, vector clusters on a spill-cut ring, and the join tree
////////////////////////////////////////////////////////////////////////////

module ara_cluster_top import cluster_pkg::*; import op_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  // Host request
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  op_t      req_op_i,
  input  operand_t req_operand_i,
  // Vector response
  output logic     resp_valid_o,
  input  logic     resp_ready_i,
  output vec_t     resp_data_o
);

  req_stream_if root_if ();
  req_stream_if leaf_if [NrClusters] ();

  // Ring links before and after the spill cuts
  logic  [NrClusters-1:0] ring_out_valid, ring_out_ready;
  logic  [NrClusters-1:0] ring_in_valid, ring_in_ready;
  elem_t [NrClusters-1:0] ring_out_data, ring_in_data;

  logic  [NrClusters-1:0] elem_valid, elem_ready;
  elem_t [NrClusters-1:0] elem_data;

  assign root_if.valid   = req_valid_i;
  assign root_if.op      = req_op_i;
  assign root_if.operand = req_operand_i;
  assign req_ready_o     = root_if.ready;

  req_fork_tree i_req_fork_tree (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .root   (root_if),
    .leaves (leaf_if)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clusters and ring
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NrClusters; i++) begin : p_cluster
    vector_cluster #(
      .ClusterId(cluster_id_t'(i))
    ) i_vector_cluster (
      .clk_i       (clk_i            ),
      .reset_i     (reset_i          ),
      .req         (leaf_if[i]       ),
      .ring_valid_o(ring_out_valid[i]),
      .ring_data_o (ring_out_data[i] ),
      .ring_ready_i(ring_out_ready[i]),
      .ring_valid_i(ring_in_valid[i] ),
      .ring_data_i (ring_in_data[i]  ),
      .ring_ready_o(ring_in_ready[i] ),
      .resp_valid_o(elem_valid[i]    ),
      .resp_data_o (elem_data[i]     ),
      .resp_ready_i(elem_ready[i]    )
    );

    // Cut between cluster i and its right neighbour, last one wraps to 0
    ring_spill i_ring_spill (
      .clk_i  (clk_i                               ),
      .reset_i(reset_i                             ),
      .valid_i(ring_out_valid[i]                   ),
      .ready_o(ring_out_ready[i]                   ),
      .data_i (ring_out_data[i]                    ),
      .valid_o(ring_in_valid[(i + 1) % NrClusters] ),
      .ready_i(ring_in_ready[(i + 1) % NrClusters] ),
      .data_o (ring_in_data[(i + 1) % NrClusters]  )
    );
  end

  resp_join_tree i_resp_join_tree (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .elem_valid_i(elem_valid  ),
    .elem_ready_o(elem_ready  ),
    .elem_data_i (elem_data   ),
    .resp_valid_o(resp_valid_o),
    .resp_data_o (resp_data_o ),
    .resp_ready_i(resp_ready_i)
  );

endmodule : ara_cluster_top

/* verilog/cluster_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Cluster system sizes
// Number of clusters, tree depth, element width and vector types
////////////////////////////////////////////////////////////////////////////

package cluster_pkg;

  // Must stay a power of two for the fork and join trees
  localparam int unsigned NrClusters = 4;
  localparam int unsigned NrLevels   = $clog2(NrClusters);
  localparam int unsigned ElemWidth  = 16;

  // One element per cluster
  typedef logic [ElemWidth-1:0] elem_t;

  // Whole vector, cluster 0 in the lowest bits
  typedef logic [NrClusters*ElemWidth-1:0] vec_t;

  typedef logic [NrLevels-1:0] cluster_id_t;

endpackage : cluster_pkg

/* verilog/op_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Vector operation encodings
// Operation codes and the request operand type
////////////////////////////////////////////////////////////////////////////

package op_pkg;

  import cluster_pkg::*;

  typedef logic [1:0] op_t;

  // Code 3 is unused and behaves as ADD
  localparam op_t OpSet   = 2'd0;
  localparam op_t OpAdd   = 2'd1;
  localparam op_t OpSlide = 2'd2;

  // Operand has the element width
  typedef logic [ElemWidth-1:0] operand_t;

endpackage : op_pkg

/* verilog/req_fork_node.sv */
////////////////////////////////////////////////////////////////////////////
// Request fork node
// Registers one request and broadcasts it to two children
////////////////////////////////////////////////////////////////////////////

module req_fork_node import op_pkg::*; (
  input  logic           clk_i,
  input  logic           reset_i,
  req_stream_if.receiver in,
  req_stream_if.sender   out_a,
  req_stream_if.sender   out_b
);

  // One pending bit per child
  logic     pend_a_q;
  logic     pend_b_q;
  op_t      op_q;
  operand_t operand_q;
  logic     accept;

  // New request only once both children have taken the old one
  assign in.ready = ~pend_a_q & ~pend_b_q;
  assign accept   = in.valid & in.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_a_q <= 1'b0;
      pend_b_q <= 1'b0;
    end else if (accept) begin
      pend_a_q <= 1'b1;
      pend_b_q <= 1'b1;
    end else begin
      if (out_a.ready) pend_a_q <= 1'b0;
      if (out_b.ready) pend_b_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= in.op;
      operand_q <= in.operand;
    end
  end

  // Same payload on both sides
  assign out_a.valid   = pend_a_q;
  assign out_a.op      = op_q;
  assign out_a.operand = operand_q;
  assign out_b.valid   = pend_b_q;
  assign out_b.op      = op_q;
  assign out_b.operand = operand_q;

endmodule : req_fork_node

/* verilog/req_fork_tree.sv */
////////////////////////////////////////////////////////////////////////////
// Request fork tree
// Binary tree of fork nodes from the host request to every cluster
////////////////////////////////////////////////////////////////////////////

module req_fork_tree import cluster_pkg::*; (
  input  logic           clk_i,
  input  logic           reset_i,
  req_stream_if.receiver root,
  req_stream_if.sender   leaves [NrClusters]
);

  // Heap numbering, link k feeds links 2k and 2k+1
  req_stream_if links [1:2*NrClusters-1] ();

  assign links[1].valid   = root.valid;
  assign links[1].op      = root.op;
  assign links[1].operand = root.operand;
  assign root.ready       = links[1].ready;

  for (genvar l = 0; l < NrLevels; l++) begin : p_level
    for (genvar n = 0; n < (1 << l); n++) begin : p_fork
      localparam int unsigned Idx = (1 << l) + n;

      req_fork_node i_fork_node (
        .clk_i  (clk_i          ),
        .reset_i(reset_i        ),
        .in     (links[Idx]     ),
        .out_a  (links[2*Idx]   ),
        .out_b  (links[2*Idx+1] )
      );
    end
  end

  // Last level of links goes out to the clusters
  for (genvar i = 0; i < NrClusters; i++) begin : p_leaf
    assign leaves[i].valid           = links[NrClusters+i].valid;
    assign leaves[i].op              = links[NrClusters+i].op;
    assign leaves[i].operand         = links[NrClusters+i].operand;
    assign links[NrClusters+i].ready = leaves[i].ready;
  end

endmodule : req_fork_tree

/* verilog/req_stream_if.sv */
////////////////////////////////////////////////////////////////////////////
// Request stream
// Valid/ready link carrying one vector operation and its operand
////////////////////////////////////////////////////////////////////////////

interface req_stream_if import op_pkg::*; ();

  logic     valid;
  logic     ready;
  op_t      op;
  operand_t operand;

  // Upstream side
  modport sender (
    output valid,
    output op,
    output operand,
    input  ready
  );

  // Downstream side
  modport receiver (
    input  valid,
    input  op,
    input  operand,
    output ready
  );

endinterface : req_stream_if

/* verilog/resp_join_tree.sv */
////////////////////////////////////////////////////////////////////////////
// Response join tree
// Registered binary tree merging cluster answers into one vector
////////////////////////////////////////////////////////////////////////////

module resp_join_tree import cluster_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic  [NrClusters-1:0] elem_valid_i,
  output logic  [NrClusters-1:0] elem_ready_o,
  input  elem_t [NrClusters-1:0] elem_data_i,
  output logic                   resp_valid_o,
  output vec_t                   resp_data_o,
  input  logic                   resp_ready_i
);

  // Each level covers the whole vector, node n at the matching slice
  vec_t                    lvl_data [NrLevels+1];
  // Heap numbering, node 1 is the root and leaves start at NrClusters
  logic [2*NrClusters-1:1] node_valid;
  logic [2*NrClusters-1:1] node_ready;

  assign lvl_data[0] = elem_data_i;

  for (genvar i = 0; i < NrClusters; i++) begin : p_leaf
    assign node_valid[NrClusters+i] = elem_valid_i[i];
    assign elem_ready_o[i]          = node_ready[NrClusters+i];
  end

  for (genvar l = 1; l <= NrLevels; l++) begin : p_level
    localparam int unsigned NodeWidth = ElemWidth << l;
    localparam int unsigned NrNodes   = NrClusters >> l;

    for (genvar n = 0; n < NrNodes; n++) begin : p_join
      localparam int unsigned Idx = NrNodes + n;

      logic                 valid_q;
      logic [NodeWidth-1:0] data_q;
      logic                 load;

      // Both children drain together
      assign load = node_valid[2*Idx] & node_valid[2*Idx+1] & (~valid_q | node_ready[Idx]);
      assign node_ready[2*Idx]   = load;
      assign node_ready[2*Idx+1] = load;

      always_ff @(posedge clk_i) begin
        if (reset_i)              valid_q <= 1'b0;
        else if (load)            valid_q <= 1'b1;
        else if (node_ready[Idx]) valid_q <= 1'b0;
      end

      // Lower child lands in the low half
      always_ff @(posedge clk_i) begin
        if (load) data_q <= lvl_data[l-1][n*NodeWidth +: NodeWidth];
      end

      assign node_valid[Idx]                       = valid_q;
      assign lvl_data[l][n*NodeWidth +: NodeWidth] = data_q;
    end
  end

  assign node_ready[1] = resp_ready_i;
  assign resp_valid_o  = node_valid[1];
  assign resp_data_o   = lvl_data[NrLevels];

endmodule : resp_join_tree

/* verilog/ring_spill.sv */
////////////////////////////////////////////////////////////////////////////
// Ring spill register
// Two-slot cut on one ring link, registers data and ready
////////////////////////////////////////////////////////////////////////////

module ring_spill import cluster_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  elem_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output elem_t data_o
);

  logic  a_full_q, b_full_q;
  elem_t a_data_q, b_data_q;
  logic  a_fill, a_drain;
  logic  b_fill, b_drain;

  // Slot A takes input, slot B holds the older entry on a stall
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill | a_drain) a_full_q <= a_fill;
      if (b_fill | b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Ready from state only
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule : ring_spill

/* verilog/vector_cluster.sv */
////////////////////////////////////////////////////////////////////////////
// Vector cluster
// Holds one element and runs SET, ADD and SLIDE over the ring
////////////////////////////////////////////////////////////////////////////

module vector_cluster import cluster_pkg::*; import op_pkg::*; #(
  parameter cluster_id_t ClusterId = '0
) (
  input  logic           clk_i,
  input  logic           reset_i,
  // Request from the fork tree
  req_stream_if.receiver req,
  // Ring towards the right neighbour
  output logic           ring_valid_o,
  output elem_t          ring_data_o,
  input  logic           ring_ready_i,
  // Ring from the left neighbour
  input  logic           ring_valid_i,
  input  elem_t          ring_data_i,
  output logic           ring_ready_o,
  // Answer to the join tree
  output logic           resp_valid_o,
  output elem_t          resp_data_o,
  input  logic           resp_ready_i
);

  typedef enum logic [1:0] {
    Idle,
    SendRing,
    WaitRing,
    Respond
  } state_e;

  state_e state_q, state_d;
  elem_t  elem_q, elem_d;

  ////////////////////////////////////////////////////////////////////////////
  // Operation FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    elem_d  = elem_q;
    unique case (state_q)
      Idle: begin
        if (req.valid) begin
          unique case (req.op)
            OpSet: begin
              elem_d  = req.operand + elem_t'(ClusterId);
              state_d = Respond;
            end
            // Old element leaves first
            OpSlide: state_d = SendRing;
            default: begin
              elem_d  = elem_q + req.operand;
              state_d = Respond;
            end
          endcase
        end
      end
      SendRing: begin
        if (ring_ready_i) state_d = WaitRing;
      end
      WaitRing: begin
        if (ring_valid_i) begin
          elem_d  = ring_data_i;
          state_d = Respond;
        end
      end
      Respond: begin
        if (resp_ready_i) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= Idle;
      elem_q  <= '0;
    end else begin
      state_q <= state_d;
      elem_q  <= elem_d;
    end
  end

  assign req.ready    = (state_q == Idle);
  assign ring_valid_o = (state_q == SendRing);
  assign ring_data_o  = elem_q;
  assign ring_ready_o = (state_q == WaitRing);
  assign resp_valid_o = (state_q == Respond);
  assign resp_data_o  = elem_q;

endmodule : vector_cluster
